// File: Bender.yml
package:
  name: mc_top

sources:
  - files:
      - hw/noc_pkg.sv
      - hw/mem_pkg.sv
      - hw/mc_rst_seq.sv
      - hw/mc_queue.sv
      - hw/noc_req_decoder.sv
      - hw/mc_ctrl.sv
      - hw/model_mem.sv
      - hw/noc_resp_encoder.sv
      - hw/mc_top.sv
  - target: simulation
    files:
      - dv/mc_tb.sv

// File: dv/mc_tb.sv
`default_nettype none

module mc_tb;

  localparam int DELAY_CYCLES = 20;
  localparam int MEM_WORDS    = 64;
  localparam int WAIT_LIMIT   = 2000;  // cycles per wait loop

  typedef struct packed {
    noc_pkg::noc_hdr_t  hdr;
    noc_pkg::noc_flit_t data;  // only used for load acks
  } exp_resp_t;

  logic               core_ref_clk;
  logic               sys_rst_n;
  noc_pkg::noc_flit_t mc_flit_in_data;
  logic               mc_flit_in_val;
  logic               mc_flit_in_rdy;
  noc_pkg::noc_flit_t mc_flit_out_data;
  logic               mc_flit_out_val;
  logic               mc_flit_out_rdy;
  logic               mc_ui_clk_sync_rst;
  logic               init_calib_complete_out;

  exp_resp_t          exp_q[$];
  noc_pkg::noc_flit_t ref_mem [int unsigned];  // sparse model memory
  logic               ack_data_pending;
  logic               bp_on;
  logic               gap_on;
  int                 rel_edges;

  mc_top #(
    .DELAY_CYCLES (DELAY_CYCLES),
    .MEM_WORDS    (MEM_WORDS)
  ) DUT (
    .core_ref_clk            (core_ref_clk),
    .sys_rst_n               (sys_rst_n),
    .mc_flit_in_data         (mc_flit_in_data),
    .mc_flit_in_val          (mc_flit_in_val),
    .mc_flit_in_rdy          (mc_flit_in_rdy),
    .mc_flit_out_data        (mc_flit_out_data),
    .mc_flit_out_val         (mc_flit_out_val),
    .mc_flit_out_rdy         (mc_flit_out_rdy),
    .mc_ui_clk_sync_rst      (mc_ui_clk_sync_rst),
    .init_calib_complete_out (init_calib_complete_out)
  );

  initial begin
    core_ref_clk = 1'b0;
    forever #10 core_ref_clk = ~core_ref_clk;
  end

  // rising edges seen with reset released
  always @(posedge core_ref_clk) begin
    rel_edges <= sys_rst_n ? rel_edges + 1 : 0;
  end

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_hdr(input noc_pkg::noc_hdr_t got, input noc_pkg::noc_hdr_t exp,
                           input string what);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s header %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_data(input noc_pkg::noc_flit_t got, input noc_pkg::noc_flit_t exp,
                            input string what);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s flit %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  // expected ack for one request with memory indexed by byte address / 8 mod MEM_WORDS
  function automatic exp_resp_t ref_model(input noc_pkg::noc_hdr_t req,
                                          input noc_pkg::noc_flit_t wdata);
    exp_resp_t   r;
    int unsigned idx;
    idx          = (req.addr / 8) % MEM_WORDS;
    r.hdr.mshrid = req.mshrid;
    r.hdr.rsvd   = '0;
    r.hdr.addr   = '0;
    if (req.msg_type == noc_pkg::MSG_STORE_MEM) begin
      ref_mem[idx]   = wdata;
      r.hdr.msg_type = noc_pkg::MSG_STORE_MEM_ACK;
      r.data         = '0;
    end else begin
      r.hdr.msg_type = noc_pkg::MSG_LOAD_MEM_ACK;
      r.data         = ref_mem.exists(idx) ? ref_mem[idx] : '0;  // unwritten reads zero
    end
    return r;
  endfunction

  // random ready on the output side and compare every accepted flit
  initial begin : out_monitor
    exp_resp_t cur;
    cur              = '0;
    ack_data_pending = 1'b0;
    forever begin
      @(negedge core_ref_clk);
      check_level(mc_ui_clk_sync_rst, rel_edges < DELAY_CYCLES + 1, "mc_ui_clk_sync_rst");
      check_level(init_calib_complete_out, rel_edges >= DELAY_CYCLES + 1,
                  "init_calib_complete_out");
      mc_flit_out_rdy = bp_on ? (($urandom % 4) != 0) : 1'b1;
      if (mc_flit_out_val === 1'b1 && mc_flit_out_rdy) begin
        if (ack_data_pending) begin
          check_data(mc_flit_out_data, cur.data, "load ack data");
          ack_data_pending = 1'b0;
        end else if (exp_q.size() == 0) begin
          $display("FAILED at time %0t: unexpected flit %h", $time, mc_flit_out_data);
          stop_on_error();
        end else begin
          cur = exp_q.pop_front();
          check_hdr(noc_pkg::noc_hdr_t'(mc_flit_out_data), cur.hdr, "ack");
          ack_data_pending = (cur.hdr.msg_type == noc_pkg::MSG_LOAD_MEM_ACK);
        end
      end
    end
  end

  // called at a falling edge and returns at the falling edge after the transfer
  task automatic send_flit(input noc_pkg::noc_flit_t flit);
    int waited;
    waited = 0;
    if (gap_on) begin
      repeat ($urandom % 3) @(negedge core_ref_clk);
    end
    mc_flit_in_val  = 1'b1;
    mc_flit_in_data = flit;
    while (!mc_flit_in_rdy) begin
      @(negedge core_ref_clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timed out waiting for mc_flit_in_rdy to accept a request flit");
        stop_on_error();
      end
    end
    @(negedge core_ref_clk);
    mc_flit_in_val  = 1'b0;
    mc_flit_in_data = '0;
  endtask

  task automatic send_req(input logic [7:0] mtype, input logic [7:0] mshrid,
                          input logic [31:0] addr, input noc_pkg::noc_flit_t wdata);
    noc_pkg::noc_hdr_t hdr;
    hdr.msg_type = noc_pkg::msg_type_t'(mtype);
    hdr.mshrid   = mshrid;
    hdr.rsvd     = '0;
    hdr.addr     = addr;
    if (mtype == noc_pkg::MSG_LOAD_MEM || mtype == noc_pkg::MSG_STORE_MEM) begin
      exp_q.push_back(ref_model(hdr, wdata));
    end
    send_flit(noc_pkg::noc_flit_t'(hdr));
    if (mtype == noc_pkg::MSG_STORE_MEM) begin
      send_flit(wdata);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || ack_data_pending) begin
      @(negedge core_ref_clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timed out waiting for %0d outstanding acks", exp_q.size());
        stop_on_error();
      end
    end
    repeat (10) @(negedge core_ref_clk);  // let any stray flit show up
  endtask

  task automatic check_reset_release();
    noc_pkg::noc_hdr_t hdr;
    hdr.msg_type = noc_pkg::MSG_LOAD_MEM;
    hdr.mshrid   = 8'h01;
    hdr.rsvd     = '0;
    hdr.addr     = 32'h0000_0008;
    check_level(mc_ui_clk_sync_rst, 1'b1, "mc_ui_clk_sync_rst in reset");
    check_level(mc_flit_in_rdy, 1'b1, "mc_flit_in_rdy after reset");
    exp_q.push_back(ref_model(hdr, '0));
    sys_rst_n       = 1'b1;
    mc_flit_in_val  = 1'b1;  // queued early, held back until calibration
    mc_flit_in_data = noc_pkg::noc_flit_t'(hdr);
    for (int edge_n = 1; edge_n <= DELAY_CYCLES + 5; edge_n++) begin
      @(negedge core_ref_clk);
      if (edge_n == 1) begin
        mc_flit_in_val  = 1'b0;
        mc_flit_in_data = '0;
      end
      check_level(mc_ui_clk_sync_rst, edge_n < DELAY_CYCLES + 1, "mc_ui_clk_sync_rst");
      if (edge_n <= DELAY_CYCLES + 1) begin
        check_level(mc_flit_out_val, 1'b0, "mc_flit_out_val before calibration");
      end
    end
  endtask

  task automatic run_random(input int n);
    logic [7:0]         mtype;
    logic [31:0]        addr;
    noc_pkg::noc_flit_t wdata;
    for (int i = 0; i < n; i++) begin
      if (($urandom % 5) == 0) begin
        mtype = 8'($urandom % 256);
        if (mtype == noc_pkg::MSG_LOAD_MEM || mtype == noc_pkg::MSG_STORE_MEM) begin
          mtype = 8'd3;
        end
        send_req(mtype, 8'($urandom), 32'($urandom), '0);  // dropped without an ack
      end
      mtype = (($urandom % 2) != 0) ? noc_pkg::MSG_STORE_MEM : noc_pkg::MSG_LOAD_MEM;
      addr  = 32'((($urandom % 160) * 8) + ($urandom % 8));  // spans aliases
      wdata = {$urandom, $urandom};
      send_req(mtype, 8'(i), addr, wdata);
    end
  endtask

  initial begin : main
    sys_rst_n       = 1'b0;
    mc_flit_in_data = '0;
    mc_flit_in_val  = 1'b0;
    mc_flit_out_rdy = 1'b0;
    bp_on           = 1'b0;
    gap_on          = 1'b0;
    void'($urandom(32'h9cc5_72bf));
    repeat (5) @(negedge core_ref_clk);
    check_reset_release();

    // store then load to the same word
    send_req(noc_pkg::MSG_STORE_MEM, 8'h11, 32'h0000_0040, 64'hdead_beef_0123_4567);
    send_req(noc_pkg::MSG_LOAD_MEM, 8'h12, 32'h0000_0040, '0);
    wait_drain();

    // unwritten word then aliasing 64 words apart
    send_req(noc_pkg::MSG_LOAD_MEM, 8'h20, 32'h0000_0100, '0);
    send_req(noc_pkg::MSG_STORE_MEM, 8'h21, 32'h0000_0028, 64'h5a5a_a5a5_0f0f_f0f0);
    send_req(8'h07, 8'h2f, 32'h0000_0028, '0);
    send_req(noc_pkg::MSG_LOAD_MEM, 8'h22, 32'h0000_0228, '0);
    send_req(noc_pkg::MSG_LOAD_MEM, 8'h23, 32'h0000_042d, '0);
    wait_drain();

    run_random(200);
    wait_drain();

    bp_on  = 1'b1;  // random stalls on both sides
    gap_on = 1'b1;
    run_random(200);
    wait_drain();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/mc_ctrl.sv
`default_nettype none

module mc_ctrl #(
  parameter int QUEUE_DEPTH = 2
) (
  input  wire                                   core_ref_clk,
  input  wire                                   sys_rst_n,
  input  wire                                   calib_done,
  input  wire mem_pkg::mem_req_t                req,
  input  wire                                   req_val,
  output logic                                  req_rdy,
  input  wire [$clog2(QUEUE_DEPTH+1)-1:0]       resp_free_slots,
  output logic                                  mem_en,
  output logic                                  mem_we,
  output logic [31:0]                           mem_addr,
  output logic [noc_pkg::NOC_DATA_W-1:0]        mem_wdata,
  input  wire  [noc_pkg::NOC_DATA_W-1:0]        mem_rdata,
  output mem_pkg::mem_resp_t                    resp,
  output logic                                  resp_val
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic       credit_ok;
  logic       issue;
  logic       stage_val;     // result in the memory stage
  logic       stage_store;
  logic [7:0] stage_mshrid;

  // the staged result still needs a slot of its own
  assign credit_ok = (resp_free_slots > CNT_W'(stage_val));
  assign req_rdy   = calib_done & credit_ok;
  assign issue     = req_val & req_rdy;

  assign mem_en    = issue;
  assign mem_we    = issue & req.we;
  assign mem_addr  = req.addr;
  assign mem_wdata = req.wdata;

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      stage_val <= 1'b0;
    end else begin
      stage_val <= issue;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (issue) begin
      stage_store  <= req.we;
      stage_mshrid <= req.mshrid;
    end
  end

  assign resp_val      = stage_val;  // pushed the cycle after issue
  assign resp.is_store = stage_store;
  assign resp.mshrid   = stage_mshrid;
  assign resp.rdata    = stage_store ? '0 : mem_rdata;

endmodule

`default_nettype wire

// File: hw/mc_queue.sv
`default_nettype none

module mc_queue #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  wire                         core_ref_clk,
  input  wire                         sys_rst_n,
  input  wire payload_t               push_data,
  input  wire                         push_val,
  output logic                        push_rdy,
  output payload_t                    pop_data,
  output logic                        pop_val,
  input  wire                         pop_rdy,
  output logic [$clog2(DEPTH+1)-1:0]  free_slots
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         slots [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_fire;
  logic             pop_fire;

  assign push_rdy   = (count != CNT_W'(DEPTH));  // full drops ready
  assign pop_val    = (count != '0);
  assign pop_data   = slots[rd_ptr];
  assign free_slots = CNT_W'(DEPTH) - count;       // credits for the controller
  assign push_fire  = push_val & push_rdy;
  assign pop_fire   = pop_val & pop_rdy;

  always_ff @(posedge core_ref_clk) begin
    if (push_fire) begin
      slots[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/mc_rst_seq.sv
`default_nettype none

module mc_rst_seq #(
  parameter int DELAY_CYCLES = 511
) (
  input  wire  core_ref_clk,
  input  wire  sys_rst_n,
  output logic mc_ui_clk_sync_rst,
  output logic calib_done
);

  localparam int CNT_W = (DELAY_CYCLES > 0) ? $clog2(DELAY_CYCLES + 1) : 1;

  logic [CNT_W-1:0] delay_cnt;

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      delay_cnt <= CNT_W'(DELAY_CYCLES);  // reload on every reset
    end else if (delay_cnt != '0) begin
      delay_cnt <= delay_cnt - 1'b1;
    end
  end

  // drops one edge after the count hits zero
  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      mc_ui_clk_sync_rst <= 1'b1;
    end else begin
      mc_ui_clk_sync_rst <= (delay_cnt != '0);
    end
  end

  assign calib_done = ~mc_ui_clk_sync_rst;

endmodule

`default_nettype wire

// File: hw/mc_top.sv
`default_nettype none

module mc_top #(
  parameter int DELAY_CYCLES = 511,
  parameter int QUEUE_DEPTH  = 2,
  parameter int MEM_WORDS    = 256
) (
  input  wire                      core_ref_clk,
  input  wire                      sys_rst_n,
  input  wire noc_pkg::noc_flit_t  mc_flit_in_data,
  input  wire                      mc_flit_in_val,
  output logic                     mc_flit_in_rdy,
  output noc_pkg::noc_flit_t       mc_flit_out_data,
  output logic                     mc_flit_out_val,
  input  wire                      mc_flit_out_rdy,
  output logic                     mc_ui_clk_sync_rst,
  output logic                     init_calib_complete_out
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  mem_pkg::mem_req_t              dec_req;
  logic                           dec_req_val;
  logic                           dec_req_rdy;
  mem_pkg::mem_req_t              q_req;
  logic                           q_req_val;
  logic                           q_req_rdy;
  mem_pkg::mem_resp_t             ctrl_resp;
  logic                           ctrl_resp_val;
  logic [CNT_W-1:0]               resp_free_slots;
  mem_pkg::mem_resp_t             q_resp;
  logic                           q_resp_val;
  logic                           q_resp_rdy;
  logic                           mem_en;
  logic                           mem_we;
  logic [31:0]                    mem_addr;
  logic [noc_pkg::NOC_DATA_W-1:0] mem_wdata;
  logic [noc_pkg::NOC_DATA_W-1:0] mem_rdata;

  mc_rst_seq #(.DELAY_CYCLES(DELAY_CYCLES)) u_rst_seq (
    .core_ref_clk       (core_ref_clk),
    .sys_rst_n          (sys_rst_n),
    .mc_ui_clk_sync_rst (mc_ui_clk_sync_rst),
    .calib_done         (init_calib_complete_out)  // also gates issue
  );

  noc_req_decoder u_req_dec (
    .core_ref_clk (core_ref_clk),
    .sys_rst_n    (sys_rst_n),
    .flit_in_data (mc_flit_in_data),
    .flit_in_val  (mc_flit_in_val),
    .flit_in_rdy  (mc_flit_in_rdy),
    .req          (dec_req),
    .req_val      (dec_req_val),
    .req_rdy      (dec_req_rdy)
  );

  mc_queue #(.payload_t(mem_pkg::mem_req_t), .DEPTH(QUEUE_DEPTH)) u_req_q (
    .core_ref_clk (core_ref_clk),
    .sys_rst_n    (sys_rst_n),
    .push_data    (dec_req),
    .push_val     (dec_req_val),
    .push_rdy     (dec_req_rdy),
    .pop_data     (q_req),
    .pop_val      (q_req_val),
    .pop_rdy      (q_req_rdy),
    .free_slots   ()
  );

  mc_ctrl #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_ctrl (
    .core_ref_clk    (core_ref_clk),
    .sys_rst_n       (sys_rst_n),
    .calib_done      (init_calib_complete_out),
    .req             (q_req),
    .req_val         (q_req_val),
    .req_rdy         (q_req_rdy),
    .resp_free_slots (resp_free_slots),
    .mem_en          (mem_en),
    .mem_we          (mem_we),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_rdata       (mem_rdata),
    .resp            (ctrl_resp),
    .resp_val        (ctrl_resp_val)
  );

  model_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .core_ref_clk (core_ref_clk),
    .en           (mem_en),
    .we           (mem_we),
    .addr         (mem_addr),
    .wdata        (mem_wdata),
    .rdata        (mem_rdata)
  );

  // push never stalls, the controller only issues against free slots
  mc_queue #(.payload_t(mem_pkg::mem_resp_t), .DEPTH(QUEUE_DEPTH)) u_resp_q (
    .core_ref_clk (core_ref_clk),
    .sys_rst_n    (sys_rst_n),
    .push_data    (ctrl_resp),
    .push_val     (ctrl_resp_val),
    .push_rdy     (),
    .pop_data     (q_resp),
    .pop_val      (q_resp_val),
    .pop_rdy      (q_resp_rdy),
    .free_slots   (resp_free_slots)
  );

  noc_resp_encoder u_resp_enc (
    .core_ref_clk  (core_ref_clk),
    .sys_rst_n     (sys_rst_n),
    .resp          (q_resp),
    .resp_val      (q_resp_val),
    .resp_rdy      (q_resp_rdy),
    .flit_out_data (mc_flit_out_data),
    .flit_out_val  (mc_flit_out_val),
    .flit_out_rdy  (mc_flit_out_rdy)
  );

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // request from the NoC decoder to the controller
  typedef struct packed {
    logic                           we;      // store when set
    logic [7:0]                     mshrid;
    logic [31:0]                    addr;    // byte address
    logic [noc_pkg::NOC_DATA_W-1:0] wdata;
  } mem_req_t;

  // result handed to the ack encoder
  typedef struct packed {
    logic                           is_store;
    logic [7:0]                     mshrid;
    logic [noc_pkg::NOC_DATA_W-1:0] rdata;   // zero for stores
  } mem_resp_t;

endpackage

`default_nettype wire

// File: hw/model_mem.sv
`default_nettype none

module model_mem #(
  parameter int MEM_WORDS = 256
) (
  input  wire                              core_ref_clk,
  input  wire                              en,
  input  wire                              we,
  input  wire  [31:0]                      addr,
  input  wire  [noc_pkg::NOC_DATA_W-1:0]   wdata,
  output logic [noc_pkg::NOC_DATA_W-1:0]   rdata
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [noc_pkg::NOC_DATA_W-1:0] mem_array [MEM_WORDS];
  logic [IDX_W-1:0]               idx;

  assign idx = IDX_W'(addr[31:3] % MEM_WORDS);  // 8-byte words, wraps

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_array[i] = '0;
    end
  end

  always @(posedge core_ref_clk) begin
    if (en && we) begin
      mem_array[idx] <= wdata;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (en) begin
      rdata <= mem_array[idx];  // old data on a store
    end
  end

endmodule

`default_nettype wire

// File: hw/noc_pkg.sv
`default_nettype none

package noc_pkg;

  localparam int NOC_DATA_W = 64;

  typedef logic [NOC_DATA_W-1:0] noc_flit_t;

  // message types used by the memory controller
  typedef enum logic [7:0] {
    MSG_LOAD_MEM      = 8'd19,
    MSG_STORE_MEM     = 8'd20,
    MSG_LOAD_MEM_ACK  = 8'd24,
    MSG_STORE_MEM_ACK = 8'd25
  } msg_type_t;

  // header flit, msb first
  typedef struct packed {
    msg_type_t   msg_type;
    logic [7:0]  mshrid;  // echoed back in the ack
    logic [15:0] rsvd;    // always zero
    logic [31:0] addr;    // byte address
  } noc_hdr_t;

endpackage

`default_nettype wire

// File: hw/noc_req_decoder.sv
`default_nettype none

module noc_req_decoder (
  input  wire                      core_ref_clk,
  input  wire                      sys_rst_n,
  input  wire noc_pkg::noc_flit_t  flit_in_data,
  input  wire                      flit_in_val,
  output logic                     flit_in_rdy,
  output mem_pkg::mem_req_t        req,
  output logic                     req_val,
  input  wire                      req_rdy
);

  typedef enum logic {ST_HDR, ST_DATA} state_t;

  state_t            state_q;
  noc_pkg::noc_hdr_t hdr_in;
  noc_pkg::noc_hdr_t hdr_q;    // store header waiting for its data
  logic              is_load;
  logic              is_store;
  logic              in_fire;

  assign hdr_in      = noc_pkg::noc_hdr_t'(flit_in_data);
  assign is_load     = (hdr_in.msg_type == noc_pkg::MSG_LOAD_MEM);
  assign is_store    = (hdr_in.msg_type == noc_pkg::MSG_STORE_MEM);
  assign flit_in_rdy = req_rdy;  // no flit taken while the queue is full
  assign in_fire     = flit_in_val & flit_in_rdy;

  always_comb begin
    if (state_q == ST_DATA) begin
      req_val    = flit_in_val;
      req.we     = 1'b1;
      req.mshrid = hdr_q.mshrid;
      req.addr   = hdr_q.addr;
      req.wdata  = flit_in_data;
    end else begin
      req_val    = flit_in_val & is_load;  // stores and unknown types push nothing here
      req.we     = 1'b0;
      req.mshrid = hdr_in.mshrid;
      req.addr   = hdr_in.addr;
      req.wdata  = '0;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      state_q <= ST_HDR;
    end else if (in_fire) begin
      case (state_q)
        ST_HDR:  state_q <= is_store ? ST_DATA : ST_HDR;
        ST_DATA: state_q <= ST_HDR;
        default: state_q <= ST_HDR;
      endcase
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (in_fire && state_q == ST_HDR && is_store) begin
      hdr_q <= hdr_in;
    end
  end

endmodule

`default_nettype wire

// File: hw/noc_resp_encoder.sv
`default_nettype none

module noc_resp_encoder (
  input  wire                      core_ref_clk,
  input  wire                      sys_rst_n,
  input  wire mem_pkg::mem_resp_t  resp,
  input  wire                      resp_val,
  output logic                     resp_rdy,
  output noc_pkg::noc_flit_t       flit_out_data,
  output logic                     flit_out_val,
  input  wire                      flit_out_rdy
);

  typedef enum logic {ST_HDR, ST_DATA} state_t;

  state_t            state_q;
  noc_pkg::noc_hdr_t ack_hdr;
  logic              out_fire;

  always_comb begin
    ack_hdr.msg_type = resp.is_store ? noc_pkg::MSG_STORE_MEM_ACK
                                     : noc_pkg::MSG_LOAD_MEM_ACK;
    ack_hdr.mshrid   = resp.mshrid;
    ack_hdr.rsvd     = '0;
    ack_hdr.addr     = '0;
  end

  // queue head stays put until popped
  assign flit_out_val  = resp_val;
  assign flit_out_data = (state_q == ST_DATA) ? resp.rdata : noc_pkg::noc_flit_t'(ack_hdr);
  assign out_fire      = flit_out_val & flit_out_rdy;

  // pop with the last flit of the message
  assign resp_rdy = flit_out_rdy & ((state_q == ST_DATA) | resp.is_store);

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      state_q <= ST_HDR;
    end else if (out_fire) begin
      case (state_q)
        ST_HDR:  state_q <= resp.is_store ? ST_HDR : ST_DATA;
        ST_DATA: state_q <= ST_HDR;
        default: state_q <= ST_HDR;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mc_top.f
hw/noc_pkg.sv
hw/mem_pkg.sv
hw/mc_rst_seq.sv
hw/mc_queue.sv
hw/noc_req_decoder.sv
hw/mc_ctrl.sv
hw/model_mem.sv
hw/noc_resp_encoder.sv
hw/mc_top.sv
dv/mc_tb.sv
